//--- rtl/rv_decode_defs.svh
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// Datapath width of the RV32I core
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// Machine exception PC
`define RV_MEPC_ADDR 12'h341

// MRET  funct7=0011000 rs2=00010 rs1=0 funct3=0 rd=0 opcode=SYSTEM
`define RV_MRET_IR 32'b0011000_00010_00000_000_00000_1110011

// ECALL is the all-zero SYSTEM word
`define RV_ECALL_IR 32'b000000000000_00000_000_00000_1110011

`endif

//--- rtl/rv_pkg.sv
package rv_pkg;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // Immediate layouts
    typedef enum logic [2:0] {
        IMM_I     = 3'd0,
        IMM_S     = 3'd1,
        IMM_B     = 3'd2,
        IMM_U     = 3'd3,
        IMM_J     = 3'd4,
        IMM_SHAMT = 3'd5,
        IMM_CSR   = 3'd6,
        IMM_NONE  = 3'd7
    } imm_type_e;

endpackage

//--- rtl/if_id_reg.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module if_id_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                ir_valid,
    input  logic [`RV_XLEN-1:0] ir,
    output logic                id_valid,
    output logic [`RV_XLEN-1:0] id_ir
);

    // Strobe follows the input every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            id_valid <= 1'b0;
        end else begin
            id_valid <= ir_valid;
        end
    end

    // Word is only captured with its strobe
    always_ff @(posedge clk) begin
        if (ir_valid) begin
            id_ir <= ir;
        end
    end

    // A strobed word must be fully driven
    a_ir_known: assert property (@(posedge clk) disable iff (rst)
        ir_valid |-> !$isunknown(ir))
        else $error("instruction word has unknown bits while ir_valid is high");

endmodule

//--- rtl/imm_extractor.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module imm_extractor (
    input  logic [`RV_XLEN-1:0] ir,
    input  rv_pkg::imm_type_e   imm_type,
    output logic [`RV_XLEN-1:0] imm
);

    always_comb begin
        case (imm_type)
            rv_pkg::IMM_I: begin
                imm = {{(`RV_XLEN-12){ir[31]}}, ir[31:20]};
            end
            rv_pkg::IMM_S: begin
                imm = {{(`RV_XLEN-12){ir[31]}}, ir[31:25], ir[11:7]};
            end
            // Branch offsets are in halfwords, bit 0 is always zero
            rv_pkg::IMM_B: begin
                imm = {{(`RV_XLEN-12){ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
            end
            rv_pkg::IMM_U: begin
                imm = {ir[31:12], 12'b0};
            end
            rv_pkg::IMM_J: begin
                imm = {{(`RV_XLEN-20){ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
            end
            // Shift amount lives in the rs2 field
            rv_pkg::IMM_SHAMT: begin
                imm = {{(`RV_XLEN-5){1'b0}}, ir[24:20]};
            end
            // zimm of CSRRxI lives in the rs1 field
            rv_pkg::IMM_CSR: begin
                imm = {{(`RV_XLEN-5){1'b0}}, ir[19:15]};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

//--- rtl/id_decoder.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module id_decoder (
    input  logic [`RV_XLEN-1:0] id_ir,
    input  logic                is_e_cause_eq_ecall,
    output logic [4:0]          rs1,
    output logic [4:0]          rs2,
    output logic [4:0]          rd,
    output rv_pkg::opcode_e     opcode,
    output logic [2:0]          funct3,
    output logic [6:0]          funct7,
    output logic [11:0]         csr_addr,
    output logic [`RV_XLEN-1:0] imm,
    output logic                wr_reg_n,
    output logic                wr_csr_n,
    output logic                is_mret,
    output logic                is_ecall,
    output logic                is_illegal_ir
);

    rv_pkg::imm_type_e   imm_type;
    logic [`RV_XLEN-1:0] raw_imm;
    logic                is_csr;
    logic                is_csrr;

    // Field split
    assign opcode = rv_pkg::opcode_e'(id_ir[6:0]);
    assign rd     = id_ir[11:7];
    assign funct3 = id_ir[14:12];
    assign rs1    = id_ir[19:15];
    assign rs2    = id_ir[24:20];
    assign funct7 = id_ir[31:25];

    assign is_mret  = (id_ir == `RV_MRET_IR);
    assign is_ecall = (id_ir == `RV_ECALL_IR);

    // MRET reads mepc so the return target can be forwarded
    assign csr_addr = is_mret ? `RV_MEPC_ADDR : id_ir[31:20];

    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC:  imm_type = rv_pkg::IMM_U;
            rv_pkg::OPC_JAL:    imm_type = rv_pkg::IMM_J;
            rv_pkg::OPC_JALR,
            rv_pkg::OPC_LOAD:   imm_type = rv_pkg::IMM_I;
            rv_pkg::OPC_BRANCH: imm_type = rv_pkg::IMM_B;
            rv_pkg::OPC_STORE:  imm_type = rv_pkg::IMM_S;
            rv_pkg::OPC_OP_IMM: begin
                // SLLI, SRLI and SRAI carry a shift amount
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm_type = rv_pkg::IMM_SHAMT;
                end else begin
                    imm_type = rv_pkg::IMM_I;
                end
            end
            rv_pkg::OPC_SYSTEM: imm_type = rv_pkg::IMM_CSR;
            default:            imm_type = rv_pkg::IMM_NONE;
        endcase
    end

    imm_extractor imm_extractor_inst (
        .ir       (id_ir),
        .imm_type (imm_type),
        .imm      (raw_imm)
    );

    // Return from an ECALL trap resumes at mepc + 4, other traps at mepc
    // (raw_imm is zero for MRET since its rs1 field is x0)
    assign imm = (is_mret && is_e_cause_eq_ecall) ? `RV_XLEN'd4 : raw_imm;

    // Legality per the RV32I funct3/funct7 tables
    always_comb begin
        case (opcode)
            rv_pkg::OPC_LUI,
            rv_pkg::OPC_AUIPC,
            rv_pkg::OPC_JAL:    is_illegal_ir = 1'b0;
            rv_pkg::OPC_JALR:   is_illegal_ir = (funct3 != 3'b000);
            rv_pkg::OPC_BRANCH: is_illegal_ir = (funct3 == 3'b010) || (funct3 == 3'b011);
            rv_pkg::OPC_LOAD:   is_illegal_ir = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            rv_pkg::OPC_STORE:  is_illegal_ir = (funct3 > 3'b010);
            rv_pkg::OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    is_illegal_ir = (funct7 != 7'b0000000);
                end else if (funct3 == 3'b101) begin
                    is_illegal_ir = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end else begin
                    is_illegal_ir = 1'b0;
                end
            end
            rv_pkg::OPC_OP: begin
                // Only ADD/SUB and SRL/SRA have an alternate funct7
                if (funct3 == 3'b000 || funct3 == 3'b101) begin
                    is_illegal_ir = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                end else begin
                    is_illegal_ir = (funct7 != 7'b0000000);
                end
            end
            rv_pkg::OPC_SYSTEM: begin
                // funct3 000 is only MRET or ECALL here, 100 is unused
                if (funct3 == 3'b000) begin
                    is_illegal_ir = !(is_mret || is_ecall);
                end else begin
                    is_illegal_ir = (funct3 == 3'b100);
                end
            end
            default:            is_illegal_ir = 1'b1;
        endcase
    end

    assign is_csr  = (opcode == rv_pkg::OPC_SYSTEM) && (funct3 != 3'b000);
    // CSRR pseudo-op only reads the CSR
    assign is_csrr = is_csr && (funct3 == 3'b010) && (rs1 == 5'd0);

    // Whitelist of kinds that write rd
    always_comb begin
        wr_reg_n = 1'b1;
        if (!is_illegal_ir && rd != 5'd0) begin
            case (opcode)
                rv_pkg::OPC_LUI,
                rv_pkg::OPC_AUIPC,
                rv_pkg::OPC_JAL,
                rv_pkg::OPC_JALR,
                rv_pkg::OPC_LOAD,
                rv_pkg::OPC_OP_IMM,
                rv_pkg::OPC_OP:     wr_reg_n = 1'b0;
                rv_pkg::OPC_SYSTEM: wr_reg_n = !is_csr;
                default:            wr_reg_n = 1'b1;
            endcase
        end
    end

    assign wr_csr_n = is_illegal_ir || !is_csr || is_csrr;

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic                wb_en,
    input  logic [4:0]          wb_addr,
    input  logic [`RV_XLEN-1:0] wb_data,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != 5'd0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // No bypass, a same-edge write is seen one cycle later
    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        ((rs1 != 5'd0) || (rs1_data == '0)) && ((rs2 != 5'd0) || (rs2_data == '0)))
        else $error("x0 read returned a nonzero value");

endmodule

//--- rtl/id_ex_reg.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module id_ex_reg (
    input  logic                clk,
    input  logic                rst,
    input  logic                id_valid,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rd,
    input  rv_pkg::opcode_e     opcode,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic [11:0]         csr_addr,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic                wr_reg_n,
    input  logic                wr_csr_n,
    input  logic                is_mret,
    input  logic                is_ecall,
    input  logic                is_illegal_ir,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic                ex_valid,
    output logic [4:0]          ex_rd,
    output rv_pkg::opcode_e     ex_opcode,
    output logic [2:0]          ex_funct3,
    output logic [6:0]          ex_funct7,
    output logic [11:0]         ex_csr_addr,
    output logic [`RV_XLEN-1:0] ex_imm,
    output logic [`RV_XLEN-1:0] ex_rs1_data,
    output logic [`RV_XLEN-1:0] ex_rs2_data,
    output logic                ex_wr_reg_n,
    output logic                ex_wr_csr_n,
    output logic                ex_is_mret,
    output logic                ex_is_ecall,
    output logic                ex_is_illegal_ir
);

    // Control side, a missing instruction becomes a bubble
    always_ff @(posedge clk) begin
        if (rst || !id_valid) begin
            ex_valid         <= 1'b0;
            ex_wr_reg_n      <= 1'b1;
            ex_wr_csr_n      <= 1'b1;
            ex_is_mret       <= 1'b0;
            ex_is_ecall      <= 1'b0;
            ex_is_illegal_ir <= 1'b0;
        end else begin
            ex_valid         <= 1'b1;
            ex_wr_reg_n      <= wr_reg_n;
            ex_wr_csr_n      <= wr_csr_n;
            ex_is_mret       <= is_mret;
            ex_is_ecall      <= is_ecall;
            ex_is_illegal_ir <= is_illegal_ir;
        end
    end

    // Payload holds the last valid bundle
    always_ff @(posedge clk) begin
        if (id_valid) begin
            ex_rd       <= rd;
            ex_opcode   <= opcode;
            ex_funct3   <= funct3;
            ex_funct7   <= funct7;
            ex_csr_addr <= csr_addr;
            ex_imm      <= imm;
            ex_rs1_data <= rs1_data;
            ex_rs2_data <= rs2_data;
        end
    end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (rst)
        (ex_valid && ex_is_illegal_ir) |-> (ex_wr_reg_n && ex_wr_csr_n))
        else $error("illegal instruction carries an active write enable");

    // CSRRS with x0 source reaches execute as a read-only CSR access
    a_csrr_no_csr_write: assert property (@(posedge clk) disable iff (rst)
        (id_valid && opcode == rv_pkg::OPC_SYSTEM && funct3 == 3'b010 && rs1 == 5'd0)
        |=> ex_wr_csr_n)
        else $error("CSRRS with rs1 = x0 enabled a CSR write");

endmodule

//--- rtl/rv_decode_top.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module rv_decode_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                ir_valid,
    input  logic [`RV_XLEN-1:0] ir,
    input  logic                is_e_cause_eq_ecall,
    input  logic                wb_en,
    input  logic [4:0]          wb_addr,
    input  logic [`RV_XLEN-1:0] wb_data,
    output logic                ex_valid,
    output logic [4:0]          ex_rd,
    output rv_pkg::opcode_e     ex_opcode,
    output logic [2:0]          ex_funct3,
    output logic [6:0]          ex_funct7,
    output logic [11:0]         ex_csr_addr,
    output logic [`RV_XLEN-1:0] ex_imm,
    output logic [`RV_XLEN-1:0] ex_rs1_data,
    output logic [`RV_XLEN-1:0] ex_rs2_data,
    output logic                ex_wr_reg_n,
    output logic                ex_wr_csr_n,
    output logic                ex_is_mret,
    output logic                ex_is_ecall,
    output logic                ex_is_illegal_ir
);

    logic                id_valid;
    logic [`RV_XLEN-1:0] id_ir;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    rv_pkg::opcode_e     opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [11:0]         csr_addr;
    logic [`RV_XLEN-1:0] imm;
    logic                wr_reg_n;
    logic                wr_csr_n;
    logic                is_mret;
    logic                is_ecall;
    logic                is_illegal_ir;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    if_id_reg if_id_reg_inst (
        .clk      (clk),
        .rst      (rst),
        .ir_valid (ir_valid),
        .ir       (ir),
        .id_valid (id_valid),
        .id_ir    (id_ir)
    );

    id_decoder id_decoder_inst (
        .id_ir               (id_ir),
        .is_e_cause_eq_ecall (is_e_cause_eq_ecall),
        .rs1                 (rs1),
        .rs2                 (rs2),
        .rd                  (rd),
        .opcode              (opcode),
        .funct3              (funct3),
        .funct7              (funct7),
        .csr_addr            (csr_addr),
        .imm                 (imm),
        .wr_reg_n            (wr_reg_n),
        .wr_csr_n            (wr_csr_n),
        .is_mret             (is_mret),
        .is_ecall            (is_ecall),
        .is_illegal_ir       (is_illegal_ir)
    );

    reg_file reg_file_inst (
        .clk      (clk),
        .rst      (rst),
        .rs1      (rs1),
        .rs2      (rs2),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    id_ex_reg id_ex_reg_inst (
        .clk              (clk),
        .rst              (rst),
        .id_valid         (id_valid),
        .rs1              (rs1),
        .rd               (rd),
        .opcode           (opcode),
        .funct3           (funct3),
        .funct7           (funct7),
        .csr_addr         (csr_addr),
        .imm              (imm),
        .wr_reg_n         (wr_reg_n),
        .wr_csr_n         (wr_csr_n),
        .is_mret          (is_mret),
        .is_ecall         (is_ecall),
        .is_illegal_ir    (is_illegal_ir),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .ex_valid         (ex_valid),
        .ex_rd            (ex_rd),
        .ex_opcode        (ex_opcode),
        .ex_funct3        (ex_funct3),
        .ex_funct7        (ex_funct7),
        .ex_csr_addr      (ex_csr_addr),
        .ex_imm           (ex_imm),
        .ex_rs1_data      (ex_rs1_data),
        .ex_rs2_data      (ex_rs2_data),
        .ex_wr_reg_n      (ex_wr_reg_n),
        .ex_wr_csr_n      (ex_wr_csr_n),
        .ex_is_mret       (ex_is_mret),
        .ex_is_ecall      (ex_is_ecall),
        .ex_is_illegal_ir (ex_is_illegal_ir)
    );

endmodule

//--- testbench/tb_rv_decode.sv
`timescale 1ns/1ps

`include "rv_decode_defs.svh"

module tb_rv_decode;

    // Word as sent plus the register contents it should read
    typedef struct packed {
        logic [`RV_XLEN-1:0] word;
        logic [`RV_XLEN-1:0] rs1_val;
        logic [`RV_XLEN-1:0] rs2_val;
    } sent_t;

    typedef struct packed {
        logic [4:0]          rd;
        logic [6:0]          opcode;
        logic [2:0]          funct3;
        logic [6:0]          funct7;
        logic [11:0]         csr_addr;
        logic [`RV_XLEN-1:0] imm;
        logic [`RV_XLEN-1:0] rs1_data;
        logic [`RV_XLEN-1:0] rs2_data;
        logic                wr_reg_n;
        logic                wr_csr_n;
        logic                is_mret;
        logic                is_ecall;
        logic                is_illegal_ir;
    } bundle_t;

    logic                clk;
    logic                rst;
    logic                ir_valid;
    logic [`RV_XLEN-1:0] ir;
    logic                is_e_cause_eq_ecall;
    logic                wb_en;
    logic [4:0]          wb_addr;
    logic [`RV_XLEN-1:0] wb_data;
    logic                ex_valid;
    logic [4:0]          ex_rd;
    rv_pkg::opcode_e     ex_opcode;
    logic [2:0]          ex_funct3;
    logic [6:0]          ex_funct7;
    logic [11:0]         ex_csr_addr;
    logic [`RV_XLEN-1:0] ex_imm;
    logic [`RV_XLEN-1:0] ex_rs1_data;
    logic [`RV_XLEN-1:0] ex_rs2_data;
    logic                ex_wr_reg_n;
    logic                ex_wr_csr_n;
    logic                ex_is_mret;
    logic                ex_is_ecall;
    logic                ex_is_illegal_ir;

    logic [`RV_XLEN-1:0] shadow [`RV_NUM_REGS];
    sent_t               sent_q [$];
    sent_t               popped;
    logic                in_id;
    logic                exp_valid;
    bundle_t             exp_b;
    logic [31:0]         rng;

    rv_decode_top rv_decode_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Spread each address over all 32 bits so no two registers look alike
    function automatic logic [`RV_XLEN-1:0] fill_value(input logic [4:0] addr);
        return ({27'd0, addr} + 32'd1) * 32'h9e37_79b9;
    endfunction

    function automatic logic [6:0] pick_opcode(input logic [3:0] idx);
        case (idx)
            4'd0:    return rv_pkg::OPC_LUI;
            4'd1:    return rv_pkg::OPC_AUIPC;
            4'd2:    return rv_pkg::OPC_JAL;
            4'd3:    return rv_pkg::OPC_JALR;
            4'd4:    return rv_pkg::OPC_BRANCH;
            4'd5:    return rv_pkg::OPC_LOAD;
            4'd6:    return rv_pkg::OPC_STORE;
            4'd7:    return rv_pkg::OPC_OP_IMM;
            4'd8:    return rv_pkg::OPC_OP;
            default: return rv_pkg::OPC_SYSTEM;
        endcase
    endfunction

    // Reference decode straight from the RV32I encoding tables
    function automatic bundle_t ref_decode(input logic [31:0] w, input logic cause,
                                           input logic [31:0] r1, input logic [31:0] r2);
        bundle_t    b;
        logic       legal;
        logic       writes_rd;
        logic       csr_op;
        logic [2:0] f3;
        logic [6:0] f7;
        f3         = w[14:12];
        f7         = w[31:25];
        b.rd       = w[11:7];
        b.opcode   = w[6:0];
        b.funct3   = f3;
        b.funct7   = f7;
        b.rs1_data = r1;
        b.rs2_data = r2;
        b.is_mret  = (w == `RV_MRET_IR);
        b.is_ecall = (w == `RV_ECALL_IR);
        b.csr_addr = b.is_mret ? `RV_MEPC_ADDR : w[31:20];
        b.imm      = '0;
        legal      = 1'b1;
        writes_rd  = 1'b1;
        csr_op     = 1'b0;
        case (w[6:0])
            rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: b.imm = {w[31:12], 12'h000};
            rv_pkg::OPC_JAL: b.imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
            rv_pkg::OPC_JALR: begin
                b.imm = 32'($signed(w[31:20]));
                legal = (f3 == 3'd0);
            end
            rv_pkg::OPC_BRANCH: begin
                b.imm     = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
                legal     = (f3 != 3'd2) && (f3 != 3'd3);
                writes_rd = 1'b0;
            end
            rv_pkg::OPC_LOAD: begin
                b.imm = 32'($signed(w[31:20]));
                legal = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            rv_pkg::OPC_STORE: begin
                b.imm     = 32'($signed({w[31:25], w[11:7]}));
                legal     = (f3 <= 3'd2);
                writes_rd = 1'b0;
            end
            rv_pkg::OPC_OP_IMM: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    b.imm = {27'd0, w[24:20]};
                    legal = (f7 == 7'h00) || (f3 == 3'd5 && f7 == 7'h20);
                end else begin
                    b.imm = 32'($signed(w[31:20]));
                end
            end
            rv_pkg::OPC_OP: legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            rv_pkg::OPC_SYSTEM: begin
                b.imm     = {27'd0, w[19:15]};
                csr_op    = (f3 != 3'd0);
                legal     = csr_op ? (f3 != 3'd4) : (b.is_mret || b.is_ecall);
                writes_rd = csr_op;
            end
            default: begin
                legal     = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
        // Return from an ECALL trap steps over the ECALL itself
        if (b.is_mret && cause) begin
            b.imm = 32'd4;
        end
        b.is_illegal_ir = !legal;
        b.wr_reg_n      = !(legal && writes_rd && (w[11:7] != 5'd0));
        b.wr_csr_n      = !(legal && csr_op && !(f3 == 3'd2 && w[19:15] == 5'd0));
        return b;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // Cause level goes out one cycle after the word, while it sits in decode
    task automatic send_ir(input logic [31:0] word, input logic cause);
        sent_t entry;
        entry.word    = word;
        entry.rs1_val = shadow[word[19:15]];
        entry.rs2_val = shadow[word[24:20]];
        sent_q.push_back(entry);
        ir_valid = 1'b1;
        ir       = word;
        step();
        is_e_cause_eq_ecall = cause;
    endtask

    task automatic gap(input int cycles);
        ir_valid = 1'b0;
        for (int c = 0; c < cycles; c++) begin
            step();
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (sent_q.size() != 0 || in_id || exp_valid) begin
            if (cycles == 20) begin
                report_failure("Timed out waiting for the last bundle to leave the pipeline");
            end else begin
                step();
                cycles++;
            end
        end
    endtask

    // Model pipeline, the bundle is due two edges after the strobe
    always @(posedge clk) begin
        if (rst) begin
            in_id     <= 1'b0;
            exp_valid <= 1'b0;
        end else begin
            in_id     <= ir_valid;
            exp_valid <= in_id;
            if (in_id) begin
                if (sent_q.size() == 0) begin
                    report_failure("Decode stage holds an instruction that was never sent");
                end else begin
                    popped = sent_q.pop_front();
                    exp_b  <= ref_decode(popped.word, is_e_cause_eq_ecall,
                                         popped.rs1_val, popped.rs2_val);
                end
            end
        end
    end

    a_valid: assert property (@(posedge clk) disable iff (rst) ex_valid == exp_valid)
        else report_mismatch("ex_valid", 32'($sampled(exp_valid)), 32'($sampled(ex_valid)));
    a_bubble: assert property (@(posedge clk) disable iff (rst)
        !ex_valid |-> (ex_wr_reg_n && ex_wr_csr_n && !ex_is_mret && !ex_is_ecall
                       && !ex_is_illegal_ir))
        else report_failure("Bubble cycle shows an active write enable or flag");
    a_rd: assert property (@(posedge clk) disable iff (rst) exp_valid |-> ex_rd == exp_b.rd)
        else report_mismatch("ex_rd", 32'($sampled(exp_b.rd)), 32'($sampled(ex_rd)));
    a_opcode: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_opcode == exp_b.opcode)
        else report_mismatch("ex_opcode", 32'($sampled(exp_b.opcode)),
                             32'($sampled(ex_opcode)));
    a_funct3: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_funct3 == exp_b.funct3)
        else report_mismatch("ex_funct3", 32'($sampled(exp_b.funct3)),
                             32'($sampled(ex_funct3)));
    a_funct7: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_funct7 == exp_b.funct7)
        else report_mismatch("ex_funct7", 32'($sampled(exp_b.funct7)),
                             32'($sampled(ex_funct7)));
    a_csr_addr: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_csr_addr == exp_b.csr_addr)
        else report_mismatch("ex_csr_addr", 32'($sampled(exp_b.csr_addr)),
                             32'($sampled(ex_csr_addr)));
    a_imm: assert property (@(posedge clk) disable iff (rst) exp_valid |-> ex_imm == exp_b.imm)
        else report_mismatch("ex_imm", $sampled(exp_b.imm), $sampled(ex_imm));
    a_rs1_data: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_rs1_data == exp_b.rs1_data)
        else report_mismatch("ex_rs1_data", $sampled(exp_b.rs1_data), $sampled(ex_rs1_data));
    a_rs2_data: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_rs2_data == exp_b.rs2_data)
        else report_mismatch("ex_rs2_data", $sampled(exp_b.rs2_data), $sampled(ex_rs2_data));
    a_wr_reg_n: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_wr_reg_n == exp_b.wr_reg_n)
        else report_mismatch("ex_wr_reg_n", 32'($sampled(exp_b.wr_reg_n)),
                             32'($sampled(ex_wr_reg_n)));
    a_wr_csr_n: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_wr_csr_n == exp_b.wr_csr_n)
        else report_mismatch("ex_wr_csr_n", 32'($sampled(exp_b.wr_csr_n)),
                             32'($sampled(ex_wr_csr_n)));
    a_mret: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_is_mret == exp_b.is_mret)
        else report_mismatch("ex_is_mret", 32'($sampled(exp_b.is_mret)),
                             32'($sampled(ex_is_mret)));
    a_ecall: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_is_ecall == exp_b.is_ecall)
        else report_mismatch("ex_is_ecall", 32'($sampled(exp_b.is_ecall)),
                             32'($sampled(ex_is_ecall)));
    a_illegal: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> ex_is_illegal_ir == exp_b.is_illegal_ir)
        else report_mismatch("ex_is_illegal_ir", 32'($sampled(exp_b.is_illegal_ir)),
                             32'($sampled(ex_is_illegal_ir)));

    initial begin
        logic [31:0] r;
        logic [31:0] word;
        rst                 = 1'b1;
        ir_valid            = 1'b0;
        ir                  = '0;
        is_e_cause_eq_ecall = 1'b0;
        wb_en               = 1'b0;
        wb_addr             = '0;
        wb_data             = '0;
        rng                 = 32'd93454;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (4) step();
        rst = 1'b0;

        // x0 gets a write too, which the register file must drop
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            wb_en   = 1'b1;
            wb_addr = i[4:0];
            wb_data = fill_value(i[4:0]);
            if (i != 0) begin
                shadow[i] = wb_data;
            end
            step();
        end
        wb_en = 1'b0;
        step();

        send_ir(`RV_MRET_IR, 1'b1);
        gap(1);
        send_ir(`RV_MRET_IR, 1'b0);
        send_ir(`RV_ECALL_IR, 1'b1);
        // csrrs x5, mstatus, x0 then csrrs x6, mscratch, x7
        send_ir({12'h300, 5'd0, 3'b010, 5'd5, 7'b1110011}, 1'b0);
        send_ir({12'h340, 5'd7, 3'b010, 5'd6, 7'b1110011}, 1'b0);
        // slli carrying the srai funct7
        send_ir({7'h20, 5'd3, 5'd1, 3'b001, 5'd2, 7'b0010011}, 1'b0);
        send_ir(32'h1234_567f, 1'b0);
        // addi x0, x1, 5
        send_ir({12'd5, 5'd1, 3'b000, 5'd0, 7'b0010011}, 1'b0);
        // add x4, x0, x31 and sub x8, x9, x10
        send_ir({7'h00, 5'd31, 5'd0, 3'b000, 5'd4, 7'b0110011}, 1'b0);
        send_ir({7'h20, 5'd10, 5'd9, 3'b000, 5'd8, 7'b0110011}, 1'b0);
        gap(2);

        for (int n = 0; n < 400; n++) begin
            rng = xorshift(rng);
            r   = rng;
            rng = xorshift(rng);
            if (r[3:0] == 4'd0) begin
                word = rng;
            end else begin
                word = {rng[31:7], pick_opcode(4'(r[31:4] % 28'd10))};
            end
            send_ir(word, r[4]);
            if (r[6]) begin
                gap(int'(r[8:7]) + 1);
            end
        end
        ir_valid = 1'b0;
        drain();
        step();

        $display("sim passed");
        $finish;
    end

endmodule

//--- rv_decode.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/if_id_reg.sv
rtl/imm_extractor.sv
rtl/id_decoder.sv
rtl/reg_file.sv
rtl/id_ex_reg.sv
rtl/rv_decode_top.sv
testbench/tb_rv_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv_decode \
    -f rv_decode.f \
    -o sim_tb

sim_output=$(./obj_dir/sim_tb || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
